//--- sd_cmd_controller.f
+incdir+verilog
verilog/sd_bus_pkg.sv
verilog/sd_host_pkg.sv
verilog/sd_clock_divider.sv
verilog/sd_cmd_queue.sv
verilog/sd_cmd_master.sv
verilog/sd_cmd_serial_host.sv
verilog/sd_cmd_controller.sv
verification/sd_tb_clock.sv
verification/sd_cmd_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the command path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sd_cmd_controller_tb -f sd_cmd_controller.f \
    --Mdir obj_dir -o sd_cmd_controller_sim > build.log 2>&1 &&
./obj_dir/sd_cmd_controller_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

//--- verification/sd_cmd_input.txt
// first word: clock divisor; then per test: index argument kind action payload status
// kind 0 none 1 r48; action 0 silent 1 good 2 bad crc 3 wrong index; status timeout,crc,index
3
00 00000000 0 0 00000000 0
08 000001aa 1 1 000001aa 0
11 00001000 1 1 00000900 0
0d 12340000 1 2 00000900 2
10 00000200 1 3 00000900 1
37 00000000 1 0 00000000 4
07 56780000 0 0 00000000 0
3f a5a55a5a 1 3 c3c3c3c3 1
2a ffffffff 1 1 0f1e2d3c 0
19 00c0ffee 1 2 80000001 2

//--- verification/sd_cmd_controller_tb.sv
`default_nettype none

`include "sd_consts.svh"

module sd_cmd_controller_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD_NS = 20;
    localparam int          MAX_TESTS     = 16;
    localparam int          WORDS         = 6;
    localparam int          DEPTH         = `CMD_QUEUE_DEPTH;
    localparam logic [31:0] SEED          = 32'h17a6974b;

    // card behaviour codes in the input file
    localparam int ACT_SILENT      = 0;
    localparam int ACT_GOOD        = 1;
    localparam int ACT_BAD_CRC     = 2;
    localparam int ACT_WRONG_INDEX = 3;

    logic                  aclk;
    logic                  rst_n;
    sd_host_pkg::sd_div_t  divisor;
    logic                  req_valid;
    sd_host_pkg::cmd_req_t req;
    logic                  credit;
    logic                  rsp_valid;
    sd_host_pkg::cmd_rsp_t rsp;
    logic                  sd_clk;
    logic                  sd_cmd;
    logic                  sd_cmd_oe;
    logic                  sd_cmd_card;

    logic [31:0] stim_mem [0:WORDS*MAX_TESTS];

    sd_bus_pkg::sd_index_t     t_index   [MAX_TESTS];
    sd_bus_pkg::sd_arg_t       t_arg     [MAX_TESTS];
    sd_bus_pkg::sd_resp_kind_t t_kind    [MAX_TESTS];
    int                        t_action  [MAX_TESTS];
    sd_bus_pkg::sd_arg_t       t_payload [MAX_TESTS];
    sd_host_pkg::cmd_status_t  t_status  [MAX_TESTS];

    int     num_tests = 0;
    int     errors = 0;
    int     checks = 0;
    int     credits = DEPTH;
    int     credit_pulses = 0;
    int     rsp_count = 0;
    int     half_cycles = 0;
    int     toggles = 0;
    logic   sd_clk_q = 1'b0;
    longint limit_ns = 0;
    int     expected_ids [$];

    sd_tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) sd_tb_clock_i (.clk_o(aclk));

    sd_cmd_controller sd_cmd_controller_i (
        .aclk_i      (aclk),
        .rst_n_i     (rst_n),
        .divisor_i   (divisor),
        .req_valid_i (req_valid),
        .req_i       (req),
        .credit_o    (credit),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd),
        .sd_cmd_oe_o (sd_cmd_oe),
        .sd_cmd_i    (sd_cmd_card)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // remainder of data * x^7 divided by x^7 + x^3 + 1
    function automatic logic [6:0] crc7_of(input logic [39:0] data);
        logic [46:0] rem;
        rem = {data, 7'b0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'b1000_1001;
            end
        end
        return rem[6:0];
    endfunction

    task automatic load_tests();
        int base;
        // unwritten words hold the complement of their address, never a valid index
        for (int i = 0; i <= WORDS * MAX_TESTS; i++) begin
            stim_mem[i] = ~32'(i);
        end
        $readmemh("verification/sd_cmd_input.txt", stim_mem);
        divisor = sd_host_pkg::sd_div_t'(stim_mem[0]);
        num_tests = 0;
        base = 1;
        while (num_tests < MAX_TESTS && stim_mem[base] != ~32'(base)) begin
            t_index[num_tests]   = sd_bus_pkg::sd_index_t'(stim_mem[base]);
            t_arg[num_tests]     = stim_mem[base + 1];
            t_kind[num_tests]    = sd_bus_pkg::sd_resp_kind_t'(stim_mem[base + 2][0]);
            t_action[num_tests]  = int'(stim_mem[base + 3]);
            t_payload[num_tests] = stim_mem[base + 4];
            t_status[num_tests]  = sd_host_pkg::cmd_status_t'(stim_mem[base + 5][2:0]);
            num_tests++;
            base = base + WORDS;
        end
    endtask

    // host side, spends one credit per request
    task automatic send_requests();
        int sent;
        int gap;
        sent = 0;
        gap = 0;
        while (sent < num_tests) begin
            @(posedge aclk);
            if (gap > 0) begin
                req_valid <= 1'b0;
                gap--;
            end else if (credits - int'(req_valid) > 0) begin
                req_valid <= 1'b1;
                req       <= '{index: t_index[sent], argument: t_arg[sent],
                               resp_kind: t_kind[sent]};
                expected_ids.push_back(sent);
                sent++;
                // first two go out back to back on the initial credits
                gap = (sent < 2) ? 0 : int'($urandom_range(7, 0));
            end else begin
                req_valid <= 1'b0;
            end
        end
        @(posedge aclk);
        req_valid <= 1'b0;
    endtask

    task automatic check_frame(input int k, input logic [47:0] frame);
        string tag;
        tag = $sformatf("test %0d frame", k);
        check_value(frame[47], 1'b0, {tag, " start bit"});
        check_value(frame[46], 1'b1, {tag, " transmission bit"});
        check_value(frame[45:40], t_index[k], {tag, " index"});
        check_value(frame[39:8], t_arg[k], {tag, " argument"});
        check_value(frame[7:1], crc7_of({2'b01, t_index[k], t_arg[k]}), {tag, " crc7"});
        check_value(frame[0], 1'b1, {tag, " end bit"});
    endtask

    function automatic logic [47:0] build_reply(input int k);
        sd_bus_pkg::sd_index_t echo;
        logic [6:0]            crc;
        echo = t_index[k];
        if (t_action[k] == ACT_WRONG_INDEX) begin
            echo = echo + 1'b1;
        end
        crc = crc7_of({2'b00, echo, t_payload[k]});
        if (t_action[k] == ACT_BAD_CRC) begin
            crc = ~crc;
        end
        return {2'b00, echo, t_payload[k], crc, 1'b1};
    endfunction

    task automatic check_response(input int id);
        sd_bus_pkg::sd_arg_t exp_payload;
        string               tag;
        tag = $sformatf("test %0d response", id);
        if (t_kind[id] == sd_bus_pkg::RESP_NONE || t_action[id] == ACT_SILENT) begin
            exp_payload = '0;
        end else begin
            exp_payload = t_payload[id];
        end
        check_value(rsp.index, t_index[id], {tag, " index"});
        check_value(rsp.status, t_status[id], {tag, " status"});
        check_value(rsp.payload, exp_payload, {tag, " payload"});
    endtask

    // card: listens while the host drives, answers on falling edges
    initial begin : card_model
        int          k;
        int          nbits;
        logic [47:0] frame;
        logic [47:0] reply;
        k = 0;
        nbits = 0;
        frame = '0;
        sd_cmd_card = 1'b1;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe) begin
                frame = {frame[46:0], sd_cmd};
                nbits++;
            end
            if (nbits == `SD_FRAME_BITS) begin
                nbits = 0;
                if (k >= num_tests) begin
                    errors++;
                    $display("card received more command frames than requests were sent");
                end else begin
                    check_frame(k, frame);
                    if (t_kind[k] == sd_bus_pkg::RESP_48 && t_action[k] != ACT_SILENT) begin
                        reply = build_reply(k);
                        repeat (2) @(negedge sd_clk);
                        for (int b = 47; b >= 0; b--) begin
                            @(negedge sd_clk);
                            sd_cmd_card <= reply[b];
                        end
                        @(negedge sd_clk);
                        sd_cmd_card <= 1'b1;
                    end
                end
                k++;
            end
        end
    end

    // credit bookkeeping and response scoreboard
    always @(posedge aclk) begin : monitor
        int next_credits;
        int id;
        if (!rst_n) begin
            credits <= DEPTH;
        end else begin
            next_credits = credits + int'(credit) - int'(req_valid);
            if (credit) begin
                credit_pulses++;
            end
            if (next_credits < 0) begin
                errors++;
                $display("request sent without a credit at %0d ns", $time);
            end
            if (next_credits > DEPTH) begin
                errors++;
                $display("more credits returned than requests taken at %0d ns", $time);
            end
            credits <= next_credits;
            if (rsp_valid) begin
                if (expected_ids.size() == 0) begin
                    errors++;
                    $display("response arrived with no request outstanding at %0d ns", $time);
                end else begin
                    id = expected_ids.pop_front();
                    check_response(id);
                    rsp_count++;
                    if (rsp_count == 2) begin
                        check_value(credit_pulses, 2, "credit pulses for the first pair");
                    end
                end
            end
        end
    end

    // each SD clock phase lasts divisor+1 aclk cycles
    always @(posedge aclk) begin : sd_clock_monitor
        if (rst_n) begin
            half_cycles++;
            if (sd_clk !== sd_clk_q) begin
                if (toggles > 0) begin
                    check_value(half_cycles, divisor + 1, "SD clock half period in aclk cycles");
                end
                toggles++;
                half_cycles = 0;
            end
            sd_clk_q = sd_clk;
        end
    end

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout after %0d ns with %0d of %0d responses", $time, rsp_count, num_tests);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(SEED));
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        divisor = '0;
        load_tests();
        if (num_tests == 0) begin
            errors++;
            $display("input file holds no tests");
        end
        limit_ns = longint'(num_tests + 1) * (48 + `SD_NCR_MAX + 48) * 2 *
                   (longint'(divisor) + 1) * CLK_PERIOD_NS * 2;
        check_value(crc7_of(40'h40_0000_0000), 7'h4a, "reference crc7 of CMD0");
        repeat (2) @(posedge aclk);
        rst_n <= 1'b1;
        send_requests();
        wait (rsp_count == num_tests);
        repeat (4) @(posedge aclk);
        check_value(credit_pulses, num_tests, "total credit pulses");
        check_value(credits, DEPTH, "credits held at the end");
        check_value(expected_ids.size(), 0, "requests still waiting for a response");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/sd_tb_clock.sv
`default_nettype none

module sd_tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sd_cmd_controller.sv
`default_nettype none

module sd_cmd_controller (
    input  wire logic                  aclk_i,
    input  wire logic                  rst_n_i,
    input  wire sd_host_pkg::sd_div_t  divisor_i,
    input  wire logic                  req_valid_i,
    input  wire sd_host_pkg::cmd_req_t req_i,
    output logic                       credit_o,
    output logic                       rsp_valid_o,
    output sd_host_pkg::cmd_rsp_t      rsp_o,
    output logic                       sd_clk_o,
    output logic                       sd_cmd_o,
    output logic                       sd_cmd_oe_o,
    input  wire logic                  sd_cmd_i
);

    // edge strobes in the aclk domain
    logic sd_rise;
    logic sd_fall;

    // queue to master
    sd_host_pkg::cmd_req_t head;
    logic                  head_valid;
    logic                  pop;

    // master to serial host
    sd_bus_pkg::sd_token_t     token;
    sd_bus_pkg::sd_resp_kind_t resp_kind;
    logic                      start;
    logic                      done;
    sd_bus_pkg::sd_index_t     rx_index;
    sd_bus_pkg::sd_arg_t       rx_payload;
    sd_host_pkg::cmd_status_t  rx_status;

    sd_clock_divider sd_clock_divider_i (
        .aclk_i    (aclk_i),
        .rst_n_i   (rst_n_i),
        .divisor_i (divisor_i),
        .sd_clk_o  (sd_clk_o),
        .sd_rise_o (sd_rise),
        .sd_fall_o (sd_fall)
    );

    sd_cmd_queue sd_cmd_queue_i (
        .aclk_i       (aclk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (req_valid_i),
        .req_i        (req_i),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .credit_o     (credit_o)
    );

    sd_cmd_master sd_cmd_master_i (
        .aclk_i       (aclk_i),
        .rst_n_i      (rst_n_i),
        .head_i       (head),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .token_o      (token),
        .resp_kind_o  (resp_kind),
        .start_o      (start),
        .done_i       (done),
        .rx_index_i   (rx_index),
        .rx_payload_i (rx_payload),
        .rx_status_i  (rx_status),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

    sd_cmd_serial_host sd_cmd_serial_host_i (
        .aclk_i       (aclk_i),
        .rst_n_i      (rst_n_i),
        .sd_rise_i    (sd_rise),
        .sd_fall_i    (sd_fall),
        .token_i      (token),
        .resp_kind_i  (resp_kind),
        .start_i      (start),
        .done_o       (done),
        .rx_index_o   (rx_index),
        .rx_payload_o (rx_payload),
        .rx_status_o  (rx_status),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_oe_o  (sd_cmd_oe_o),
        .sd_cmd_i     (sd_cmd_i)
    );

endmodule

`default_nettype wire

//--- verilog/sd_cmd_serial_host.sv
`default_nettype none

`include "sd_consts.svh"

module sd_cmd_serial_host (
    input  wire logic                      aclk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      sd_rise_i,
    input  wire logic                      sd_fall_i,
    input  wire sd_bus_pkg::sd_token_t     token_i,
    input  wire sd_bus_pkg::sd_resp_kind_t resp_kind_i,
    input  wire logic                      start_i,
    output logic                           done_o,
    output sd_bus_pkg::sd_index_t          rx_index_o,
    output sd_bus_pkg::sd_arg_t            rx_payload_o,
    output sd_host_pkg::cmd_status_t       rx_status_o,
    output logic                           sd_cmd_o,
    output logic                           sd_cmd_oe_o,
    input  wire logic                      sd_cmd_i
);

    localparam int FRAME_W = `SD_FRAME_BITS;
    localparam int CNT_W   = $clog2(FRAME_W + 1);
    localparam int NCR_W   = $clog2(`SD_NCR_MAX);

    localparam logic [CNT_W-1:0] TOKEN_BITS = CNT_W'(`SD_TOKEN_W);
    localparam logic [CNT_W-1:0] END_BIT    = CNT_W'(FRAME_W - 1);
    localparam logic [CNT_W-1:0] FRAME_BITS = CNT_W'(FRAME_W);
    localparam logic [NCR_W-1:0] NCR_LAST   = NCR_W'(`SD_NCR_MAX - 1);

    sd_bus_pkg::sd_host_state_t state;
    sd_bus_pkg::sd_resp_kind_t  kind_q;
    sd_bus_pkg::sd_crc7_t       crc;
    logic [FRAME_W-1:0]         shreg;
    logic [CNT_W-1:0]           bit_cnt;
    logic [NCR_W-1:0]           ncr_cnt;
    logic                       tx_bit;
    logic                       timeout_q;
    logic                       crc_err_q;

    // CRC7, x^7 + x^3 + 1, one bit per call
    function automatic sd_bus_pkg::sd_crc7_t crc7_next(input sd_bus_pkg::sd_crc7_t c,
                                                       input logic din);
        logic fb;
        fb = din ^ c[6];
        return {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    // token bits, then CRC msb first, then end bit
    always_comb begin
        if (bit_cnt < TOKEN_BITS) begin
            tx_bit = shreg[FRAME_W-1];
        end else if (bit_cnt < END_BIT) begin
            tx_bit = crc[6];
        end else begin
            tx_bit = 1'b1;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i) begin
            state       <= sd_bus_pkg::HOST_IDLE;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            timeout_q   <= 1'b0;
            crc_err_q   <= 1'b0;
            bit_cnt     <= '0;
            ncr_cnt     <= '0;
        end else begin
            case (state)
                sd_bus_pkg::HOST_IDLE: begin
                    if (start_i) begin
                        state     <= sd_bus_pkg::HOST_TX;
                        bit_cnt   <= '0;
                        timeout_q <= 1'b0;
                        crc_err_q <= 1'b0;
                    end
                end
                sd_bus_pkg::HOST_TX: begin
                    if (sd_fall_i) begin
                        if (bit_cnt == FRAME_BITS) begin
                            // end bit has had its full period
                            sd_cmd_o    <= 1'b1;
                            sd_cmd_oe_o <= 1'b0;
                            ncr_cnt     <= '0;
                            state       <= (kind_q == sd_bus_pkg::RESP_48) ?
                                           sd_bus_pkg::HOST_WAIT : sd_bus_pkg::HOST_DONE;
                        end else begin
                            sd_cmd_o    <= tx_bit;
                            sd_cmd_oe_o <= 1'b1;
                            bit_cnt     <= bit_cnt + 1'b1;
                        end
                    end
                end
                sd_bus_pkg::HOST_WAIT: begin
                    if (sd_rise_i) begin
                        if (!sd_cmd_i) begin
                            state   <= sd_bus_pkg::HOST_RX;
                            bit_cnt <= CNT_W'(1);
                        end else if (ncr_cnt == NCR_LAST) begin
                            timeout_q <= 1'b1;
                            state     <= sd_bus_pkg::HOST_DONE;
                        end else begin
                            ncr_cnt <= ncr_cnt + 1'b1;
                        end
                    end
                end
                sd_bus_pkg::HOST_RX: begin
                    if (sd_rise_i) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == END_BIT) begin
                            // received CRC sits in the low bits before the end bit shifts in
                            crc_err_q <= (shreg[6:0] != crc);
                            state     <= sd_bus_pkg::HOST_DONE;
                        end
                    end
                end
                default: begin
                    state <= sd_bus_pkg::HOST_IDLE;
                end
            endcase
        end
    end

    // shift register and CRC are shared by both directions
    always_ff @(posedge aclk_i) begin
        if (state == sd_bus_pkg::HOST_IDLE && start_i) begin
            shreg  <= {token_i, 8'hff};
            crc    <= '0;
            kind_q <= resp_kind_i;
        end else if (state == sd_bus_pkg::HOST_TX && sd_fall_i && bit_cnt != FRAME_BITS) begin
            shreg <= {shreg[FRAME_W-2:0], 1'b1};
            crc   <= (bit_cnt < TOKEN_BITS) ? crc7_next(crc, tx_bit) : {crc[5:0], 1'b0};
        end else if (state == sd_bus_pkg::HOST_WAIT && sd_rise_i) begin
            // start bit is zero, so the CRC stays zero after it
            shreg <= {shreg[FRAME_W-2:0], sd_cmd_i};
            crc   <= '0;
        end else if (state == sd_bus_pkg::HOST_RX && sd_rise_i) begin
            shreg <= {shreg[FRAME_W-2:0], sd_cmd_i};
            if (bit_cnt < TOKEN_BITS) begin
                crc <= crc7_next(crc, sd_cmd_i);
            end
        end
    end

    assign done_o       = (state == sd_bus_pkg::HOST_DONE);
    assign rx_index_o   = shreg[45:40];
    assign rx_payload_o = shreg[39:8];

    always_comb begin
        rx_status_o.timeout   = timeout_q;
        rx_status_o.crc_err   = crc_err_q;
        rx_status_o.index_err = 1'b0;
    end

    // the line is only driven while a command goes out
    assert property (@(posedge aclk_i) disable iff (!rst_n_i)
        sd_cmd_oe_o |-> (state == sd_bus_pkg::HOST_TX));

endmodule

`default_nettype wire

//--- verilog/sd_cmd_master.sv
`default_nettype none

module sd_cmd_master (
    input  wire logic                       aclk_i,
    input  wire logic                       rst_n_i,
    input  wire sd_host_pkg::cmd_req_t      head_i,
    input  wire logic                       head_valid_i,
    output logic                            pop_o,
    output sd_bus_pkg::sd_token_t           token_o,
    output sd_bus_pkg::sd_resp_kind_t       resp_kind_o,
    output logic                            start_o,
    input  wire logic                       done_i,
    input  wire sd_bus_pkg::sd_index_t      rx_index_i,
    input  wire sd_bus_pkg::sd_arg_t        rx_payload_i,
    input  wire sd_host_pkg::cmd_status_t   rx_status_i,
    output logic                            rsp_valid_o,
    output sd_host_pkg::cmd_rsp_t           rsp_o
);

    logic                     busy;
    logic                     no_payload;
    sd_host_pkg::cmd_status_t status;

    // take a new head only when nothing is in flight
    assign pop_o = head_valid_i & ~busy;

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i) begin
            busy        <= 1'b0;
            start_o     <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            if (pop_o) begin
                busy <= 1'b1;
            end else if (done_i) begin
                busy <= 1'b0;
            end
            start_o     <= pop_o;
            rsp_valid_o <= done_i;
        end
    end

    // token and kind stay put for the whole command
    always_ff @(posedge aclk_i) begin
        if (pop_o) begin
            token_o.start        <= 1'b0;
            token_o.transmission <= 1'b1;
            token_o.index        <= head_i.index;
            token_o.argument     <= head_i.argument;
            resp_kind_o          <= head_i.resp_kind;
        end
    end

    // index check is meaningless without a response
    always_comb begin
        status           = rx_status_i;
        status.index_err = (resp_kind_o == sd_bus_pkg::RESP_48) && !rx_status_i.timeout &&
                           (rx_index_i != token_o.index);
    end

    assign no_payload = (resp_kind_o == sd_bus_pkg::RESP_NONE) || rx_status_i.timeout;

    always_ff @(posedge aclk_i) begin
        if (done_i) begin
            rsp_o.index   <= token_o.index;
            rsp_o.status  <= status;
            rsp_o.payload <= no_payload ? '0 : rx_payload_i;
        end
    end

    // a second start before the serial host finishes would clobber its frame
    assert property (@(posedge aclk_i) disable iff (!rst_n_i)
        (busy && !done_i) |=> !start_o);

endmodule

`default_nettype wire

//--- verilog/sd_cmd_queue.sv
`default_nettype none

`include "sd_consts.svh"

module sd_cmd_queue (
    input  wire logic                  aclk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  push_i,
    input  wire sd_host_pkg::cmd_req_t req_i,
    input  wire logic                  pop_i,
    output sd_host_pkg::cmd_req_t      head_o,
    output logic                       head_valid_o,
    output logic                       credit_o
);

    localparam int DEPTH = `CMD_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    sd_host_pkg::cmd_req_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // payload storage
    always_ff @(posedge aclk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // each popped entry hands one credit back
            credit_o <= pop_i;
        end
    end

    assign head_o       = mem[rd_ptr];
    assign head_valid_o = (count != '0);

    // host must hold a credit to push
    assert property (@(posedge aclk_i) disable iff (!rst_n_i)
        !(push_i && (count == CNT_FULL)));

    // master only takes a head that is there
    assert property (@(posedge aclk_i) disable iff (!rst_n_i)
        !(pop_i && (count == '0)));

endmodule

`default_nettype wire

//--- verilog/sd_clock_divider.sv
`default_nettype none

module sd_clock_divider (
    input  wire logic                aclk_i,
    input  wire logic                rst_n_i,
    input  wire sd_host_pkg::sd_div_t divisor_i,
    output logic                     sd_clk_o,
    output logic                     sd_rise_o,
    output logic                     sd_fall_o
);

    sd_host_pkg::sd_div_t cnt;
    logic                 tick;

    // last cycle of the current half period
    // >= keeps us safe when the divisor shrinks on the fly
    assign tick = (cnt >= divisor_i);

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i) begin
            cnt      <= '0;
            sd_clk_o <= 1'b0;
        end else begin
            if (tick) begin
                cnt      <= '0;
                sd_clk_o <= ~sd_clk_o;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // strobes sit in the cycle just before the edge they announce
    assign sd_rise_o = tick & ~sd_clk_o;
    assign sd_fall_o = tick & sd_clk_o;

endmodule

`default_nettype wire

//--- verilog/sd_host_pkg.sv
`default_nettype none

`include "sd_consts.svh"

package sd_host_pkg;

    // half period of the SD clock minus one, in aclk cycles
    typedef logic [`SD_DIV_W-1:0] sd_div_t;

    // one queued command
    typedef struct packed {
        sd_bus_pkg::sd_index_t     index;
        sd_bus_pkg::sd_arg_t       argument;
        sd_bus_pkg::sd_resp_kind_t resp_kind;
    } cmd_req_t;

    // error flags of a finished command
    typedef struct packed {
        logic timeout;
        logic crc_err;
        logic index_err;
    } cmd_status_t;

    // record handed back to the host
    typedef struct packed {
        sd_bus_pkg::sd_index_t index;
        cmd_status_t           status;
        sd_bus_pkg::sd_arg_t   payload;
    } cmd_rsp_t;

endpackage

`default_nettype wire

//--- verilog/sd_bus_pkg.sv
`default_nettype none

`include "sd_consts.svh"

package sd_bus_pkg;

    // fields as they appear on the command line
    typedef logic [`SD_INDEX_W-1:0] sd_index_t;
    typedef logic [`SD_ARG_W-1:0]   sd_arg_t;
    typedef logic [`SD_CRC_W-1:0]   sd_crc7_t;

    // first 40 bits of a command frame, msb goes out first
    typedef struct packed {
        logic      start;
        logic      transmission;
        sd_index_t index;
        sd_arg_t   argument;
    } sd_token_t;

    // short responses only
    typedef enum logic [0:0] {
        RESP_NONE = 1'b0,
        RESP_48   = 1'b1
    } sd_resp_kind_t;

    // serial host FSM
    typedef enum logic [2:0] {
        HOST_IDLE = 3'd0,
        HOST_TX   = 3'd1,
        HOST_WAIT = 3'd2,
        HOST_RX   = 3'd3,
        HOST_DONE = 3'd4
    } sd_host_state_t;

endpackage

`default_nettype wire

//--- verilog/sd_consts.svh
`ifndef SD_CONSTS_SVH
`define SD_CONSTS_SVH

// command line field widths
`define SD_ARG_W        32
`define SD_INDEX_W      6
`define SD_CRC_W        7

// clock divisor width
`define SD_DIV_W        8

// token is everything ahead of the CRC
`define SD_TOKEN_W      40
`define SD_FRAME_BITS   48

// queue entries, also the credits the host starts with
`define CMD_QUEUE_DEPTH 2

// SD clock periods from command end bit to response start bit
`define SD_NCR_MAX      64

`endif
